// File: build.f
+incdir+test
rtl/bus_pkg.sv
rtl/clint_pkg.sv
rtl/mtimer.sv
rtl/msip_unit.sv
rtl/clint_mux.sv
rtl/clint.sv
test/clint_tb.sv

// File: rtl/bus_pkg.sv
package bus_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // Byte address as seen on the memory-mapped port
  typedef logic [addr_w-1:0] addr_t;

  typedef logic [data_w-1:0] data_t;

  // One strobe per byte lane, all clear marks a read
  typedef logic [strb_w-1:0] strb_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
  } bus_req_t;

  // Responses from several targets are ORed, so idle targets drive all zero
  typedef struct packed {
    logic  ready;
    data_t rdata;
  } bus_rsp_t;

endpackage

// File: rtl/clint.sv
`timescale 1ns/100ps

module clint (
  input  logic              clk,
  input  logic              rst,
  input  logic              rtc,
  input  bus_pkg::bus_req_t req,
  output bus_pkg::bus_rsp_t rsp,
  output logic              mtip,
  output logic              msip
);

  bus_pkg::bus_req_t tmr_req;
  bus_pkg::bus_req_t sip_req;
  bus_pkg::bus_rsp_t tmr_rsp;
  bus_pkg::bus_rsp_t sip_rsp;

  // Splits the port between the timer and the software interrupt register
  clint_mux i_clint_mux (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .rsp     (rsp),
    .tmr_req (tmr_req),
    .sip_req (sip_req),
    .tmr_rsp (tmr_rsp),
    .sip_rsp (sip_rsp)
  );

  mtimer i_mtimer (
    .clk  (clk),
    .rst  (rst),
    .rtc  (rtc),
    .req  (tmr_req),
    .rsp  (tmr_rsp),
    .mtip (mtip)
  );

  msip_unit i_msip_unit (
    .clk  (clk),
    .rst  (rst),
    .req  (sip_req),
    .rsp  (sip_rsp),
    .msip (msip)
  );

endmodule

// File: rtl/clint_mux.sv
`timescale 1ns/100ps

module clint_mux (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req,
  output bus_pkg::bus_rsp_t rsp,
  output bus_pkg::bus_req_t tmr_req,
  output bus_pkg::bus_req_t sip_req,
  input  bus_pkg::bus_rsp_t tmr_rsp,
  input  bus_pkg::bus_rsp_t sip_rsp
);

  logic              hit_tmr;
  logic              hit_sip;
  logic              unmap_ready;
  bus_pkg::bus_rsp_t unmap_rsp;

  // Region decode on the address bits above the region offset
  assign hit_tmr = (req.addr & clint_pkg::region_mask) == clint_pkg::timer_base;
  assign hit_sip = (req.addr & clint_pkg::region_mask) == clint_pkg::msip_base;

  // Both targets see the same fields, valid reaches only the selected one
  always_comb begin
    tmr_req       = req;
    tmr_req.valid = req.valid && hit_tmr;
    sip_req       = req;
    sip_req.valid = req.valid && hit_sip;
  end

  // Unmapped requests get a local acknowledge so the bus never stalls
  always_ff @(posedge clk) begin
    if (!rst) begin
      unmap_ready <= 1'b0;
    end else begin
      unmap_ready <= req.valid && !hit_tmr && !hit_sip && !unmap_ready;
    end
  end

  always_comb begin
    unmap_rsp.ready = unmap_ready;
    unmap_rsp.rdata = '0;
  end

  // Idle responders drive zero, so an OR merges them
  assign rsp = bus_pkg::bus_rsp_t'(tmr_rsp | sip_rsp | unmap_rsp);

  one_responder: assert property (
    @(posedge clk) disable iff (!rst)
      $onehot0({tmr_rsp.ready, sip_rsp.ready, unmap_rsp.ready})
  ) else $error("More than one target answered in the same cycle");

endmodule

// File: rtl/clint_pkg.sv
package clint_pkg;

  localparam int time_w = 64;
  localparam int region_bits = 14; // Each region spans 16 KiB

  typedef logic [time_w-1:0] time_t;

  // Offset of a register inside its region
  typedef logic [region_bits-1:0] off_t;

  // Region bases, compared under region_mask
  localparam bus_pkg::addr_t msip_base = 32'h0000_0000;
  localparam bus_pkg::addr_t timer_base = 32'h0000_4000;
  localparam bus_pkg::addr_t region_mask = 32'hffff_c000;

  // Timer region, decoded on address bits 3 to 2
  localparam off_t off_cmp_lo = 14'd0;
  localparam off_t off_cmp_hi = 14'd4;
  localparam off_t off_time_lo = 14'd8;
  localparam off_t off_time_hi = 14'd12;

  // Software interrupt region
  localparam off_t off_msip = 14'd0;

  // Compare value out of reach keeps mtip quiet after reset
  localparam time_t cmp_reset = '1;

  // Flops on the rtc input before its edge is taken
  localparam int sync_stages = 2;

endpackage

// File: rtl/msip_unit.sv
`timescale 1ns/100ps

module msip_unit (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req,
  output bus_pkg::bus_rsp_t rsp,
  output logic              msip
);

  logic           msip_q;
  logic           ready_q;
  bus_pkg::data_t rdata_q;
  logic           accept;
  logic           is_write;
  logic           at_msip;

  assign accept = req.valid && !ready_q;
  assign is_write = |req.wstrb;

  // Only one word in the region is backed by a register
  assign at_msip = req.addr[clint_pkg::region_bits-1:2] ==
                   clint_pkg::off_msip[clint_pkg::region_bits-1:2];

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
      msip_q  <= 1'b0;
    end else begin
      ready_q <= accept;
      if (accept && at_msip && req.wstrb[0]) begin
        msip_q <= req.wdata[0]; // Upper lanes carry nothing
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= (!is_write && at_msip) ? bus_pkg::data_t'(msip_q) : '0;
    end
  end

  always_comb begin
    rsp.ready = ready_q;
    rsp.rdata = ready_q ? rdata_q : '0;
  end

  // Rises and falls with the acknowledge of the write that changed it
  assign msip = msip_q;

  single_ready: assert property (
    @(posedge clk) disable iff (!rst) rsp.ready |=> !rsp.ready
  ) else $error("msip_unit answered in two consecutive cycles");

endmodule

// File: rtl/mtimer.sv
`timescale 1ns/100ps

module mtimer (
  input  logic              clk,
  input  logic              rst,
  input  logic              rtc,
  input  bus_pkg::bus_req_t req,
  output bus_pkg::bus_rsp_t rsp,
  output logic              mtip
);

  logic [clint_pkg::sync_stages-1:0] rtc_sync;
  logic                              rtc_prev;
  logic                              rtc_rise;

  clint_pkg::time_t mtime;
  clint_pkg::time_t mtimecmp;

  logic           ready_q;
  bus_pkg::data_t rdata_q;
  bus_pkg::data_t read_word;
  logic           accept;
  logic           is_write;
  logic [1:0]     word;
  logic           cmp_lo_sel;
  logic           cmp_hi_sel;

  // rtc is a slow tick, so a plain flop chain is enough to bring it into clk
  always_ff @(posedge clk) begin
    if (!rst) begin
      rtc_sync <= '0;
      rtc_prev <= 1'b0;
    end else begin
      rtc_sync <= {rtc_sync[clint_pkg::sync_stages-2:0], rtc};
      rtc_prev <= rtc_sync[clint_pkg::sync_stages-1];
    end
  end

  assign rtc_rise = rtc_sync[clint_pkg::sync_stages-1] & ~rtc_prev;

  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime <= '0;
    end else if (rtc_rise) begin
      mtime <= mtime + 1'b1;
    end
  end

  // A request is taken once, the cycle with ready high ignores valid
  assign accept = req.valid && !ready_q;
  assign is_write = |req.wstrb;
  assign word = req.addr[3:2];
  assign cmp_lo_sel = word == clint_pkg::off_cmp_lo[3:2];
  assign cmp_hi_sel = word == clint_pkg::off_cmp_hi[3:2];

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q  <= 1'b0;
      mtimecmp <= clint_pkg::cmp_reset;
    end else begin
      ready_q <= accept;
      // Writes that land on mtime fall through here and are only acknowledged
      if (accept && is_write) begin
        for (int b = 0; b < bus_pkg::strb_w; b++) begin
          if (req.wstrb[b] && cmp_lo_sel) begin
            mtimecmp[8*b +: 8] <= req.wdata[8*b +: 8];
          end
          if (req.wstrb[b] && cmp_hi_sel) begin
            mtimecmp[32 + 8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    case (word)
      clint_pkg::off_cmp_lo[3:2]:  read_word = mtimecmp[31:0];
      clint_pkg::off_cmp_hi[3:2]:  read_word = mtimecmp[63:32];
      clint_pkg::off_time_lo[3:2]: read_word = mtime[31:0];
      clint_pkg::off_time_hi[3:2]: read_word = mtime[63:32];
      default:                     read_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= is_write ? '0 : read_word; // Writes answer with zero
    end
  end

  always_comb begin
    rsp.ready = ready_q;
    rsp.rdata = ready_q ? rdata_q : '0;
  end

  // Compare is registered, so mtip trails a change of either operand by a clock
  always_ff @(posedge clk) begin
    if (!rst) begin
      mtip <= 1'b0;
    end else begin
      mtip <= mtime >= mtimecmp;
    end
  end

  single_ready: assert property (
    @(posedge clk) disable iff (!rst) rsp.ready |=> !rsp.ready
  ) else $error("mtimer answered in two consecutive cycles");

  // First compare out of reset works on the reset values of mtime and mtimecmp
  quiet_after_reset: assert property (
    @(posedge clk) $rose(rst) |=> !mtip
  ) else $error("mtip high in the cycle after reset");

endmodule

// File: run.sh
#!/usr/bin/env bash
# Compiles the CLINT testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module clint_tb -Mdir obj_dir -o clint_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output="$(./obj_dir/clint_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: test/clint_model.svh
`ifndef CLINT_MODEL_SVH
`define CLINT_MODEL_SVH

// Byte lanes with a set strobe take the new data, the others keep the old word
function automatic bus_pkg::data_t merge_bytes(input bus_pkg::data_t old_word,
                                               input bus_pkg::data_t new_word,
                                               input bus_pkg::strb_t strb);
  bus_pkg::data_t result;
  result = old_word;
  for (int b = 0; b < 4; b++) begin
    if (strb[b]) begin
      result[8*b +: 8] = new_word[8*b +: 8];
    end
  end
  return result;
endfunction

function automatic bus_pkg::data_t expected_read(input bus_pkg::addr_t addr,
                                                 input clint_pkg::time_t mtime_val,
                                                 input clint_pkg::time_t cmp_val,
                                                 input logic msip_val);
  bus_pkg::addr_t region;
  bus_pkg::addr_t offset;
  bus_pkg::data_t result;
  region = addr & clint_pkg::region_mask;
  offset = addr & ~clint_pkg::region_mask;
  result = '0; // Unmapped space and unused words read as zero
  if (region == clint_pkg::timer_base) begin
    if (offset[3:2] == clint_pkg::off_cmp_lo[3:2]) result = cmp_val[31:0];
    if (offset[3:2] == clint_pkg::off_cmp_hi[3:2]) result = cmp_val[63:32];
    if (offset[3:2] == clint_pkg::off_time_lo[3:2]) result = mtime_val[31:0];
    if (offset[3:2] == clint_pkg::off_time_hi[3:2]) result = mtime_val[63:32];
  end else if (region == clint_pkg::msip_base) begin
    if (offset[13:2] == clint_pkg::off_msip[13:2]) begin
      result = bus_pkg::data_t'(msip_val);
    end
  end
  return result;
endfunction

function automatic logic expected_mtip(input clint_pkg::time_t mtime_val,
                                       input clint_pkg::time_t cmp_val);
  return mtime_val >= cmp_val;
endfunction

// Only lane 0 of the msip word carries the bit
function automatic logic expected_msip(input logic old_val, input bus_pkg::addr_t addr,
                                       input bus_pkg::data_t wdata,
                                       input bus_pkg::strb_t strb);
  bus_pkg::addr_t offset;
  offset = addr & ~clint_pkg::region_mask;
  if ((addr & clint_pkg::region_mask) == clint_pkg::msip_base &&
      offset[13:2] == clint_pkg::off_msip[13:2] && strb[0]) begin
    return wdata[0];
  end
  return old_val;
endfunction

`endif

// File: test/clint_tb.sv
`timescale 1ns/100ps

module clint_tb;

  localparam int clk_period = 10;
  localparam int reset_cycles = 4;
  localparam int ready_limit = 8;
  localparam int settle_cycles = 4;
  localparam int max_accesses = 60;
  localparam int max_rtc_edges = 24;
  localparam int rtc_edge_cycles = 10;
  localparam int margin_cycles = 200;
  localparam int timeout_cycles = reset_cycles + max_accesses * (ready_limit + 1) +
                                  max_rtc_edges * rtc_edge_cycles + margin_cycles;

  localparam bus_pkg::addr_t cmp_lo_addr =
    clint_pkg::timer_base | bus_pkg::addr_t'(clint_pkg::off_cmp_lo);
  localparam bus_pkg::addr_t cmp_hi_addr =
    clint_pkg::timer_base | bus_pkg::addr_t'(clint_pkg::off_cmp_hi);
  localparam bus_pkg::addr_t time_lo_addr =
    clint_pkg::timer_base | bus_pkg::addr_t'(clint_pkg::off_time_lo);
  localparam bus_pkg::addr_t time_hi_addr =
    clint_pkg::timer_base | bus_pkg::addr_t'(clint_pkg::off_time_hi);
  localparam bus_pkg::addr_t msip_addr =
    clint_pkg::msip_base | bus_pkg::addr_t'(clint_pkg::off_msip);

  logic              clk;
  logic              rst;
  logic              rtc;
  bus_pkg::bus_req_t req;
  bus_pkg::bus_rsp_t rsp;
  logic              mtip;
  logic              msip;

  // Shadow state of the DUT registers
  clint_pkg::time_t cmp_model;
  clint_pkg::time_t mtime_model; // Equals the number of rtc edges produced
  logic             msip_model;

  string test_name;
  int    errors;
  int    errors_before;
  int    tests_passed;
  int    tests_failed;

  `include "clint_model.svh"

  clint i_clint (
    .clk  (clk),
    .rst  (rst),
    .rtc  (rtc),
    .req  (req),
    .rsp  (rsp),
    .mtip (mtip),
    .msip (msip)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  // One bus transfer, entered and left on a falling edge
  task automatic access(input bus_pkg::addr_t addr, input bus_pkg::data_t wdata,
                        input bus_pkg::strb_t strb, output bus_pkg::data_t rdata);
    int waited;
    @(negedge clk);
    req.valid = 1'b1;
    req.addr  = addr;
    req.wdata = wdata;
    req.wstrb = strb;
    waited = 0;
    rdata = '0;
    do begin
      @(negedge clk);
      waited++;
    end while (!rsp.ready && waited < ready_limit);
    if (rsp.ready) begin
      rdata = rsp.rdata;
      check_value("ready latency", 1, waited);
    end else begin
      $display("ERROR %s: no ready from the DUT for address %h", test_name, addr);
      errors++;
    end
    req.valid = 1'b0;
    req.wstrb = '0;
  endtask

  task automatic write_word(input bus_pkg::addr_t addr, input bus_pkg::data_t data,
                            input bus_pkg::strb_t strb);
    bus_pkg::data_t rdata;
    access(addr, data, strb, rdata);
    check_value("write response data", '0, rdata); // Writes answer with zero
  endtask

  task automatic read_check(input string what, input bus_pkg::addr_t addr);
    bus_pkg::data_t rdata;
    access(addr, '0, '0, rdata);
    check_value(what, expected_read(addr, mtime_model, cmp_model, msip_model), rdata);
  endtask

  task automatic load_compare(input clint_pkg::time_t value);
    write_word(cmp_hi_addr, value[63:32], 4'hf);
    cmp_model[63:32] = value[63:32];
    write_word(cmp_lo_addr, value[31:0], 4'hf);
    cmp_model[31:0] = value[31:0];
  endtask

  task automatic check_mtip(input string what);
    repeat (2) @(negedge clk);
    check_value(what, expected_mtip(mtime_model, cmp_model), mtip);
  endtask

  // High and low phases of 2 to 4 clocks each
  task automatic pulse_rtc();
    int high_cycles;
    int low_cycles;
    high_cycles = 2 + $urandom_range(2);
    low_cycles = 2 + $urandom_range(2);
    @(negedge clk);
    rtc = 1'b1;
    mtime_model = mtime_model + 1;
    repeat (high_cycles) @(negedge clk);
    rtc = 1'b0;
    repeat (low_cycles) @(negedge clk);
  endtask

  task automatic settle();
    repeat (settle_cycles) @(negedge clk);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_before = errors;
  endtask

  task automatic end_test();
    if (errors == errors_before) begin
      $display("%s: ok", test_name);
      tests_passed++;
    end else begin
      $display("%s: %0d mismatches", test_name, errors - errors_before);
      tests_failed++;
    end
  endtask

  initial begin
    bus_pkg::addr_t addr;
    bus_pkg::data_t data;
    bus_pkg::data_t rdata;
    bus_pkg::strb_t strb;
    int             n;
    int             ready_count;

    void'($urandom(32'he013_7385));
    rst = 1'b0;
    rtc = 1'b0;
    req = '0;
    errors = 0;
    errors_before = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_name = "reset";
    cmp_model = clint_pkg::cmp_reset;
    mtime_model = '0;
    msip_model = 1'b0;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b1;

    begin_test("reset_state");
    check_value("mtip", expected_mtip(mtime_model, cmp_model), mtip);
    check_value("msip", msip_model, msip);
    read_check("mtimecmp low", cmp_lo_addr);
    read_check("mtimecmp high", cmp_hi_addr);
    read_check("mtime low", time_lo_addr);
    read_check("mtime high", time_hi_addr);
    read_check("msip readback", msip_addr);
    end_test();

    begin_test("cmp_strobes");
    repeat (6) begin
      addr = ($urandom_range(1) == 1) ? cmp_hi_addr : cmp_lo_addr;
      data = $urandom();
      strb = bus_pkg::strb_t'($urandom_range(15, 1));
      write_word(addr, data, strb);
      if (addr == cmp_hi_addr) begin
        cmp_model[63:32] = merge_bytes(cmp_model[63:32], data, strb);
      end else begin
        cmp_model[31:0] = merge_bytes(cmp_model[31:0], data, strb);
      end
      read_check("mtimecmp readback", addr);
    end
    write_word(time_lo_addr, $urandom(), 4'hf); // mtime is read only
    write_word(time_hi_addr, $urandom(), 4'hf);
    read_check("mtime low after write", time_lo_addr);
    read_check("mtime high after write", time_hi_addr);
    read_check("mtimecmp low after mtime write", cmp_lo_addr);
    read_check("mtimecmp high after mtime write", cmp_hi_addr);
    end_test();

    begin_test("rtc_count");
    n = 5 + $urandom_range(5);
    repeat (n) pulse_rtc();
    settle();
    read_check("mtime low", time_lo_addr);
    read_check("mtime high", time_hi_addr);
    end_test();

    begin_test("timer_irq");
    for (int k = 0; k < 3; k++) begin
      load_compare(mtime_model - 1 + k); // Below, equal, then above mtime
      check_mtip("mtip after compare write");
    end
    load_compare(mtime_model + 3);
    check_mtip("mtip with compare ahead");
    repeat (2) pulse_rtc();
    settle();
    check_mtip("mtip one tick short");
    pulse_rtc();
    settle();
    check_mtip("mtip after reaching compare");
    read_check("mtime low", time_lo_addr);
    end_test();

    begin_test("software_irq");
    for (int k = 0; k < 8; k++) begin
      // Even steps set strobe 0, odd steps clear it but keep the access a write
      if (k % 2 == 0) begin
        strb = 4'h1 | bus_pkg::strb_t'($urandom_range(15));
      end else begin
        strb = bus_pkg::strb_t'($urandom_range(7, 1) << 1);
      end
      data = $urandom();
      data[0] = ~msip_model;
      write_word(msip_addr, data, strb);
      msip_model = expected_msip(msip_model, msip_addr, data, strb);
      check_value("msip output", msip_model, msip);
      read_check("msip readback", msip_addr);
    end
    data = bus_pkg::data_t'(~msip_model);
    write_word(msip_addr + 32'd4, data, 4'hf);
    msip_model = expected_msip(msip_model, msip_addr + 32'd4, data, 4'hf);
    check_value("msip after other offset", msip_model, msip);
    read_check("msip readback", msip_addr);
    end_test();

    begin_test("unmapped");
    do begin
      addr = $urandom();
    end while ((addr & clint_pkg::region_mask) == clint_pkg::msip_base ||
               (addr & clint_pkg::region_mask) == clint_pkg::timer_base);
    access(addr, $urandom(), 4'hf, rdata);
    check_value("write response data", '0, rdata);
    ready_count = 0;
    repeat (4) begin
      @(negedge clk);
      if (rsp.ready) ready_count++;
    end
    check_value("extra ready count", 0, ready_count);
    read_check("unmapped read", addr);
    read_check("mtimecmp low", cmp_lo_addr);
    read_check("mtimecmp high", cmp_hi_addr);
    read_check("mtime low", time_lo_addr);
    read_check("msip readback", msip_addr);
    check_value("mtip", expected_mtip(mtime_model, cmp_model), mtip);
    check_value("msip", msip_model, msip);
    end_test();

    $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Bound on the run length, worked out from the access and rtc budgets above
  initial begin
    #(timeout_cycles * clk_period);
    $display("Timeout: the run did not finish within %0d clock cycles", timeout_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule
